// ==== hw/bp_pkg.sv ====
package bp_pkg;

  // Kind of a control transfer resolved in execute
  // Two bits wide, one value per resolve
  typedef enum logic [1:0] {
    // Conditional branch, direction learned by the counter
    BR_COND = 2'b00,
    // Plain jump without link
    BR_JAL  = 2'b01,
    // Jump that writes the link register, pushes the RAS
    BR_CALL = 2'b10,
    // Return through the link register, pops the RAS
    BR_RET  = 2'b11
  } br_kind_e;

  // Default address width
  parameter int XLEN_DEF = 32;

  // Default BTB size
  // Must stay a power of two since the index is a plain PC slice
  parameter int BTB_ENTRIES_DEF = 16;

  // Default return stack depth, also a power of two
  // Pointer wraps naturally at this size
  parameter int RAS_DEPTH_DEF = 4;

endpackage

// ==== hw/bp_ifs.sv ====
// Lookup group between the next-PC selector and the BTB
// Whole path is combinational within the fetch cycle
interface btb_lookup_if #(
  parameter int XLEN
);

  // Fetch PC presented for lookup
  logic [XLEN-1:0] pc;
  // Valid entry with matching tag
  logic            hit;
  // Stored target, zero on a miss
  logic [XLEN-1:0] tgt;
  // Counter high bit, zero on a miss
  logic            taken;
  // Entry was trained by a return
  logic            is_return;

  // Next-PC side drives the PC and reads the prediction
  modport requester (
    output pc,
    input  hit,
    input  tgt,
    input  taken,
    input  is_return
  );

  // BTB side answers for the PC it is given
  modport responder (
    input  pc,
    output hit,
    output tgt,
    output taken,
    output is_return
  );

endinterface

// Update group from the resolve stage into the BTB
// en is a single-cycle strobe, one entry written per strobe
interface btb_update_if #(
  parameter int XLEN
);

  logic            en;
  // PC of the resolved transfer, picks index and tag
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] tgt;
  logic            taken;
  logic            is_ret;
  // Set for plain jumps and calls alike
  logic            is_jal;

  // Resolve stage drives the whole group
  modport writer (
    output en,
    output pc,
    output tgt,
    output taken,
    output is_ret,
    output is_jal
  );

  // BTB storage samples it on the clock edge
  modport tbl (
    input en,
    input pc,
    input tgt,
    input taken,
    input is_ret,
    input is_jal
  );

endinterface

// ==== hw/bp_btb.sv ====
// Direct-mapped branch target buffer
// One entry per index, a new PC on an occupied index evicts the old one
// Direction held in a 2-bit saturating counter per entry
module bp_btb #(
  parameter int XLEN,
  parameter int NENTRIES
) (
  input logic             clk,
  input logic             rst_n,
  btb_lookup_if.responder lu,
  btb_update_if.tbl       up
);

  // Index starts at bit 2, word-aligned fetch
  localparam int IDX_W  = $clog2(NENTRIES);
  localparam int IDX_LO = 2;
  localparam int IDX_HI = IDX_LO + IDX_W - 1;
  // Tag is every PC bit above the index
  localparam int TAG_W  = XLEN - IDX_HI - 1;

  // Entry storage, only the valid bits see reset
  logic [NENTRIES-1:0] valid;
  logic [NENTRIES-1:0] ret_flag;
  logic [TAG_W-1:0]    tag_mem [NENTRIES];
  logic [XLEN-1:0]     tgt_mem [NENTRIES];
  logic [1:0]          ctr_mem [NENTRIES];

  // Lookup side
  logic [IDX_W-1:0] lu_idx;
  logic [TAG_W-1:0] lu_tag;
  logic             lu_hit;

  // Update side
  logic [IDX_W-1:0] up_idx;
  logic [TAG_W-1:0] up_tag;
  logic             up_same;
  logic [1:0]       ctr_cur;
  logic [1:0]       ctr_next;

  // Split the fetch PC into index and tag
  assign lu_idx = lu.pc[IDX_HI:IDX_LO];
  assign lu_tag = lu.pc[XLEN-1:IDX_HI+1];

  // Hit needs both a live entry and the same tag
  assign lu_hit = valid[lu_idx] && (tag_mem[lu_idx] == lu_tag);

  // Prediction outputs forced to zero on a miss
  assign lu.hit       = lu_hit;
  assign lu.tgt       = lu_hit ? tgt_mem[lu_idx] : '0;
  assign lu.taken     = lu_hit ? ctr_mem[lu_idx][1] : 1'b0;
  assign lu.is_return = lu_hit ? ret_flag[lu_idx] : 1'b0;

  // Same split for the resolved PC
  assign up_idx = up.pc[IDX_HI:IDX_LO];
  assign up_tag = up.pc[XLEN-1:IDX_HI+1];

  // Training continues only on a live entry owned by this PC
  assign up_same = valid[up_idx] && (tag_mem[up_idx] == up_tag);
  assign ctr_cur = ctr_mem[up_idx];

  // Counter next state
  always_comb begin
    if (up.is_jal || up.is_ret) begin
      // Unconditional transfers go straight to strongly taken
      ctr_next = 2'b11;
    end else if (!up_same) begin
      // Fresh entry or eviction, start weak in the resolved direction
      ctr_next = up.taken ? 2'b10 : 2'b01;
    end else if (up.taken) begin
      // Count up, hold at 3
      if (ctr_cur == 2'b11) begin
        ctr_next = ctr_cur;
      end else begin
        ctr_next = ctr_cur + 2'b01;
      end
    end else begin
      // Count down, hold at 0
      if (ctr_cur == 2'b00) begin
        ctr_next = ctr_cur;
      end else begin
        ctr_next = ctr_cur - 2'b01;
      end
    end
  end

  // Valid bits, cleared on reset and set by any write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid <= '0;
    end else if (up.en) begin
      valid[up_idx] <= 1'b1;
    end
  end

  // Entry payload
  // Whole entry rewritten on every update, which also handles eviction
  always_ff @(posedge clk) begin
    if (up.en) begin
      tag_mem[up_idx]  <= up_tag;
      tgt_mem[up_idx]  <= up.tgt;
      ctr_mem[up_idx]  <= ctr_next;
      ret_flag[up_idx] <= up.is_ret;
    end
  end

endmodule

// ==== hw/bp_ras.sv ====
// Circular return address stack
// ptr points at the current top entry
// cnt tracks how many entries are live, saturating at the depth
module bp_ras #(
  parameter int XLEN,
  parameter int RAS_DEPTH
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            push,
  input  logic            pop,
  input  logic [XLEN-1:0] push_addr,
  output logic [XLEN-1:0] top_addr,
  output logic            empty
);

  // Depth is a power of two so the pointer wraps by itself
  localparam int PTR_W = $clog2(RAS_DEPTH);
  // Count needs one more value than the pointer, 0 up to RAS_DEPTH
  localparam int CNT_W = $clog2(RAS_DEPTH + 1);

  logic [XLEN-1:0]  stack [RAS_DEPTH];
  logic [PTR_W-1:0] ptr;
  logic [PTR_W-1:0] ptr_inc;
  logic [CNT_W-1:0] cnt;
  logic             full;

  // Slot above the current top, wraps onto the oldest entry
  assign ptr_inc = ptr + 1'b1;
  assign full    = (cnt == CNT_W'(RAS_DEPTH));
  assign empty   = (cnt == '0);

  // Top of stack, meaningless while empty
  assign top_addr = stack[ptr];

  // Pointer and count
  // Push and pop are exclusive since one resolve has a single kind
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
      cnt <= '0;
    end else if (push) begin
      ptr <= ptr_inc;
      // On overflow the count holds and the oldest slot gets reused
      if (!full) begin
        cnt <= cnt + 1'b1;
      end
    end else if (pop && !empty) begin
      ptr <= ptr - 1'b1;
      cnt <= cnt - 1'b1;
    end
  end

  // Link address storage
  always_ff @(posedge clk) begin
    if (push) begin
      stack[ptr_inc] <= push_addr;
    end
  end

endmodule

// ==== hw/bp_resolve.sv ====
// Resolve stage
// Holds one execute result for a cycle, then drives the BTB write
// and the RAS push or pop from the held copy
module bp_resolve import bp_pkg::*; #(
  parameter int XLEN
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            resolve_en,
  input  logic [XLEN-1:0] resolve_pc,
  input  logic [XLEN-1:0] resolve_tgt,
  input  logic            resolve_taken,
  input  br_kind_e        resolve_kind,
  btb_update_if.writer    up,
  output logic            ras_push,
  output logic            ras_pop,
  output logic [XLEN-1:0] ras_push_addr
);

  // Held transfer
  logic            r_valid;
  logic [XLEN-1:0] r_pc;
  logic [XLEN-1:0] r_tgt;
  logic            r_taken;
  br_kind_e        r_kind;

  // Decoded kind
  logic is_call;
  logic is_ret;
  logic is_jump;

  // Strobe register, the only control state here
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= resolve_en;
    end
  end

  // Payload captured with every strobe
  // A new strobe each cycle simply replaces the previous one
  always_ff @(posedge clk) begin
    if (resolve_en) begin
      r_pc    <= resolve_pc;
      r_tgt   <= resolve_tgt;
      r_taken <= resolve_taken;
      r_kind  <= resolve_kind;
    end
  end

  // Kind decode
  assign is_call = (r_kind == BR_CALL);
  assign is_ret  = (r_kind == BR_RET);
  // Calls count as jumps for the BTB counter
  assign is_jump = (r_kind == BR_JAL) || is_call;

  // BTB update group, written at the edge after capture
  assign up.en     = r_valid;
  assign up.pc     = r_pc;
  assign up.tgt    = r_tgt;
  assign up.taken  = r_taken;
  assign up.is_ret = is_ret;
  assign up.is_jal = is_jump;

  // RAS strobes share the same edge as the BTB write
  assign ras_push      = r_valid && is_call;
  assign ras_pop       = r_valid && is_ret;
  // Link address is the instruction after the call
  assign ras_push_addr = r_pc + XLEN'(4);

endmodule

// ==== hw/bp_next_pc.sv ====
// Next fetch PC selection
// Purely combinational, same cycle as the fetch PC
module bp_next_pc #(
  parameter int XLEN
) (
  input  logic [XLEN-1:0] fetch_pc,
  btb_lookup_if.requester lu,
  input  logic [XLEN-1:0] ras_top,
  input  logic            ras_empty,
  output logic [XLEN-1:0] next_pc,
  output logic            pred_hit,
  output logic            pred_taken
);

  // Sequential fallback
  logic [XLEN-1:0] seq_pc;
  // Taken prediction from a valid entry
  logic            pred_tk;
  // Return with a usable stack top
  logic            use_ras;

  // Present the fetch PC to the BTB
  assign lu.pc = fetch_pc;

  assign seq_pc = fetch_pc + XLEN'(4);

  // Taken only counts on a hit
  assign pred_tk = lu.hit && lu.taken;

  // Empty stack falls back to the stored BTB target
  assign use_ras = pred_tk && lu.is_return && !ras_empty;

  // Priority RAS, then BTB target, then PC plus 4
  always_comb begin
    if (use_ras) begin
      next_pc = ras_top;
    end else if (pred_tk) begin
      next_pc = lu.tgt;
    end else begin
      next_pc = seq_pc;
    end
  end

  // Status straight from the lookup
  assign pred_hit   = lu.hit;
  assign pred_taken = lu.taken;

endmodule

// ==== hw/bp_top.sv ====
// Branch prediction front
// Fetch side looks up in the same cycle
// Execute side trains the BTB and RAS one edge after the resolve strobe
module bp_top import bp_pkg::*; #(
  parameter int XLEN      = XLEN_DEF,
  parameter int NENTRIES  = BTB_ENTRIES_DEF,
  parameter int RAS_DEPTH = RAS_DEPTH_DEF
) (
  input  logic            clk,
  input  logic            rst_n,

  // Fetch port
  input  logic [XLEN-1:0] fetch_pc,
  output logic [XLEN-1:0] next_pc,
  output logic            pred_hit,
  output logic            pred_taken,

  // Execute resolve port
  input  logic            resolve_en,
  input  logic [XLEN-1:0] resolve_pc,
  input  logic [XLEN-1:0] resolve_tgt,
  input  logic            resolve_taken,
  input  br_kind_e        resolve_kind
);

  // BTB lookup and update groups
  btb_lookup_if #(.XLEN(XLEN)) lu_if ();
  btb_update_if #(.XLEN(XLEN)) up_if ();

  // RAS wiring, few enough to stay plain
  logic            ras_push;
  logic            ras_pop;
  logic [XLEN-1:0] ras_push_addr;
  logic [XLEN-1:0] ras_top;
  logic            ras_empty;

  // Registers execute results, drives training
  bp_resolve #(
    .XLEN(XLEN)
  ) u_resolve (
    .clk           (clk),
    .rst_n         (rst_n),
    .resolve_en    (resolve_en),
    .resolve_pc    (resolve_pc),
    .resolve_tgt   (resolve_tgt),
    .resolve_taken (resolve_taken),
    .resolve_kind  (resolve_kind),
    .up            (up_if.writer),
    .ras_push      (ras_push),
    .ras_pop       (ras_pop),
    .ras_push_addr (ras_push_addr)
  );

  // Target and direction storage
  bp_btb #(
    .XLEN     (XLEN),
    .NENTRIES (NENTRIES)
  ) u_btb (
    .clk   (clk),
    .rst_n (rst_n),
    .lu    (lu_if.responder),
    .up    (up_if.tbl)
  );

  // Return address stack
  bp_ras #(
    .XLEN      (XLEN),
    .RAS_DEPTH (RAS_DEPTH)
  ) u_ras (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (ras_push),
    .pop       (ras_pop),
    .push_addr (ras_push_addr),
    .top_addr  (ras_top),
    .empty     (ras_empty)
  );

  // Next fetch PC mux
  bp_next_pc #(
    .XLEN(XLEN)
  ) u_next_pc (
    .fetch_pc   (fetch_pc),
    .lu         (lu_if.requester),
    .ras_top    (ras_top),
    .ras_empty  (ras_empty),
    .next_pc    (next_pc),
    .pred_hit   (pred_hit),
    .pred_taken (pred_taken)
  );

endmodule

// ==== verification/bp_ref_model.svh ====
// Behavioral model of the BTB and the RAS
// Sizes follow the package defaults used by the DUT
localparam int M_IDX_W = $clog2(BTB_ENTRIES_DEF);

logic            m_valid [BTB_ENTRIES_DEF];
logic            m_ret   [BTB_ENTRIES_DEF];
logic [XLEN-1:0] m_tag   [BTB_ENTRIES_DEF];
logic [XLEN-1:0] m_tgt   [BTB_ENTRIES_DEF];
int              m_ctr   [BTB_ENTRIES_DEF];
logic [XLEN-1:0] m_stack [RAS_DEPTH_DEF];
int              m_ptr;
int              m_cnt;

// Index from bit 2 upward, tag is everything above it
function automatic int idx_of(input logic [XLEN-1:0] pc);
  return (pc >> 2) % BTB_ENTRIES_DEF;
endfunction

function automatic logic [XLEN-1:0] tag_of(input logic [XLEN-1:0] pc);
  return pc >> (2 + M_IDX_W);
endfunction

task automatic model_reset();
  for (int i = 0; i < BTB_ENTRIES_DEF; i++) begin
    m_valid[i] = 1'b0;
  end
  m_ptr = 0;
  m_cnt = 0;
endtask

// One resolved transfer applied to the model state
task automatic model_train(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] tgt,
                           input logic taken, input br_kind_e kind);
  int   i;
  logic same;
  i    = idx_of(pc);
  same = m_valid[i] && (m_tag[i] == tag_of(pc));
  // Unconditional kinds go strongly taken
  if (kind != BR_COND) m_ctr[i] = 3;
  else if (!same) m_ctr[i] = taken ? 2 : 1;
  else if (taken && m_ctr[i] < 3) m_ctr[i] = m_ctr[i] + 1;
  else if (!taken && m_ctr[i] > 0) m_ctr[i] = m_ctr[i] - 1;
  m_valid[i] = 1'b1;
  m_tag[i]   = tag_of(pc);
  m_tgt[i]   = tgt;
  m_ret[i]   = (kind == BR_RET);
  // Call pushes the link address, wrapping over the oldest slot
  if (kind == BR_CALL) begin
    m_ptr          = (m_ptr + 1) % RAS_DEPTH_DEF;
    m_stack[m_ptr] = pc + 4;
    if (m_cnt < RAS_DEPTH_DEF) m_cnt = m_cnt + 1;
  end else if (kind == BR_RET && m_cnt > 0) begin
    m_ptr = (m_ptr + RAS_DEPTH_DEF - 1) % RAS_DEPTH_DEF;
    m_cnt = m_cnt - 1;
  end
endtask

// Expected {next_pc, pred_hit, pred_taken} for a fetch PC
function automatic logic [XLEN+1:0] predict(input logic [XLEN-1:0] pc);
  int              i;
  logic            hit;
  logic            taken;
  logic [XLEN-1:0] nxt;
  i     = idx_of(pc);
  hit   = m_valid[i] && (m_tag[i] == tag_of(pc));
  taken = hit && (m_ctr[i] >= 2);
  nxt   = pc + 4;
  if (taken) nxt = (m_ret[i] && m_cnt != 0) ? m_stack[m_ptr] : m_tgt[i];
  return {nxt, hit, taken};
endfunction

// ==== verification/bp_tb.sv ====
module bp_tb import bp_pkg::*; ();

  localparam int XLEN = XLEN_DEF;
  // Clock edges of the directed part, counted from the sequence below
  localparam int DIR_STEPS  = 80;
  localparam int RAND_N     = 400;
  localparam int MAX_CYCLES = DIR_STEPS * 3 + RAND_N * 3 + 100;

  logic            clk;
  logic            rst_n;
  logic [XLEN-1:0] fetch_pc;
  logic [XLEN-1:0] next_pc;
  logic            pred_hit;
  logic            pred_taken;
  logic            resolve_en;
  logic [XLEN-1:0] resolve_pc;
  logic [XLEN-1:0] resolve_tgt;
  logic            resolve_taken;
  br_kind_e        resolve_kind;

  int              seed = 43922;
  int              cycles = 0;
  logic [XLEN+1:0] exp_pred;

  // Model copy of the resolve register
  logic            p_valid;
  logic [XLEN-1:0] p_pc;
  logic [XLEN-1:0] p_tgt;
  logic            p_taken;
  br_kind_e        p_kind;

  `include "bp_ref_model.svh"

  bp_top #(
    .XLEN      (XLEN),
    .NENTRIES  (BTB_ENTRIES_DEF),
    .RAS_DEPTH (RAS_DEPTH_DEF)
  ) uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_pc      (fetch_pc),
    .next_pc       (next_pc),
    .pred_hit      (pred_hit),
    .pred_taken    (pred_taken),
    .resolve_en    (resolve_en),
    .resolve_pc    (resolve_pc),
    .resolve_tgt   (resolve_tgt),
    .resolve_taken (resolve_taken),
    .resolve_kind  (resolve_kind)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic check(input string name, input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("Fail: time %0t signal %s expected 0x%h actual 0x%h", $time, name, exp, act);
      $display("Testbench failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Inputs move 2 units after the rising edge
  task automatic drive(input logic en, input logic [XLEN-1:0] pc, input logic [XLEN-1:0] tgt,
                       input logic taken, input br_kind_e kind, input logic [XLEN-1:0] fpc);
    @(posedge clk);
    #2;
    resolve_en    = en;
    resolve_pc    = pc;
    resolve_tgt   = tgt;
    resolve_taken = taken;
    resolve_kind  = kind;
    fetch_pc      = fpc;
  endtask

  // Strobe plus one quiet cycle, lookup sees the write right after
  task automatic train(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] tgt,
                       input logic taken, input br_kind_e kind);
    drive(1'b1, pc, tgt, taken, kind, fetch_pc);
    drive(1'b0, pc, tgt, taken, kind, fetch_pc);
  endtask

  // Hand-written expectation on top of the model compare
  task automatic expect_pred(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] exp_next,
                             input logic exp_hit, input logic exp_taken);
    drive(1'b0, resolve_pc, resolve_tgt, resolve_taken, resolve_kind, pc);
    #30;
    check("next_pc", exp_next, next_pc);
    check("pred_hit", exp_hit, pred_hit);
    check("pred_taken", exp_taken, pred_taken);
  endtask

  // Training lands one edge after the DUT registers the strobe
  always @(posedge clk) begin
    if (!rst_n) begin
      model_reset();
      p_valid = 1'b0;
    end else begin
      if (p_valid) model_train(p_pc, p_tgt, p_taken, p_kind);
      p_valid = resolve_en;
      if (resolve_en) begin
        p_pc    = resolve_pc;
        p_tgt   = resolve_tgt;
        p_taken = resolve_taken;
        p_kind  = resolve_kind;
      end
    end
  end

  // Sample just before the next edge, outputs settled by then
  always begin
    @(posedge clk);
    #38;
    if (rst_n) begin
      exp_pred = predict(fetch_pc);
      check("next_pc", exp_pred[XLEN+1:2], next_pc);
      check("pred_hit", exp_pred[1], pred_hit);
      check("pred_taken", exp_pred[0], pred_taken);
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Testbench failed");
      $fatal(1, "Simulation timed out");
    end
  end

  initial begin
    logic [31:0] rnd;
    logic [31:0] rnd_f;
    rst_n         = 1'b0;
    fetch_pc      = '0;
    resolve_en    = 1'b0;
    resolve_pc    = '0;
    resolve_tgt   = '0;
    resolve_taken = 1'b0;
    resolve_kind  = BR_COND;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Empty BTB, everything falls through
    expect_pred(32'h0, 32'h4, 1'b0, 1'b0);
    expect_pred(32'h18, 32'h1C, 1'b0, 1'b0);
    expect_pred(32'h100, 32'h104, 1'b0, 1'b0);
    expect_pred(32'hFFFC, 32'h1_0000, 1'b0, 1'b0);

    // Conditional branch at 0x40, counter 2 then 1, then up to 3
    train(32'h40, 32'h200, 1'b1, BR_COND);
    expect_pred(32'h40, 32'h200, 1'b1, 1'b1);
    train(32'h40, 32'h200, 1'b0, BR_COND);
    expect_pred(32'h40, 32'h44, 1'b1, 1'b0);
    repeat (3) train(32'h40, 32'h200, 1'b1, BR_COND);
    expect_pred(32'h40, 32'h200, 1'b1, 1'b1);
    // Saturated, first not-taken only weakens
    train(32'h40, 32'h200, 1'b0, BR_COND);
    expect_pred(32'h40, 32'h200, 1'b1, 1'b1);
    train(32'h40, 32'h200, 1'b0, BR_COND);
    expect_pred(32'h40, 32'h44, 1'b1, 1'b0);

    // JAL ignores resolve_taken
    train(32'h84, 32'h400, 1'b0, BR_JAL);
    expect_pred(32'h84, 32'h400, 1'b1, 1'b1);

    // 0x18 and 0x58 both map to index 6
    train(32'h18, 32'h300, 1'b1, BR_COND);
    expect_pred(32'h18, 32'h300, 1'b1, 1'b1);
    // 0x58 trained up to 3 before 0x18 takes the index back
    repeat (2) train(32'h58, 32'h500, 1'b1, BR_COND);
    expect_pred(32'h58, 32'h500, 1'b1, 1'b1);
    expect_pred(32'h18, 32'h1C, 1'b0, 1'b0);
    // Re-entry restarts weak, not-taken gives 1
    train(32'h18, 32'h300, 1'b0, BR_COND);
    expect_pred(32'h18, 32'h1C, 1'b1, 1'b0);
    expect_pred(32'h58, 32'h5C, 1'b0, 1'b0);

    // Return entry at 0x3020, stack empty so the stored target wins
    train(32'h3020, 32'h7770, 1'b1, BR_RET);
    expect_pred(32'h3020, 32'h7770, 1'b1, 1'b1);
    // Nested calls
    train(32'h1000, 32'h2000, 1'b1, BR_CALL);
    expect_pred(32'h3020, 32'h1004, 1'b1, 1'b1);
    train(32'h2010, 32'h3000, 1'b1, BR_CALL);
    expect_pred(32'h3020, 32'h2014, 1'b1, 1'b1);
    train(32'h3020, 32'h2014, 1'b1, BR_RET);
    expect_pred(32'h3020, 32'h1004, 1'b1, 1'b1);
    train(32'h3020, 32'h6660, 1'b1, BR_RET);
    expect_pred(32'h3020, 32'h6660, 1'b1, 1'b1);

    // Five calls into a four-deep stack, 0x1104 gets overwritten
    for (int i = 1; i <= 5; i++) begin
      train(32'h1000 + 32'(i) * 32'h100, 32'h2000, 1'b1, BR_CALL);
    end
    expect_pred(32'h3020, 32'h1504, 1'b1, 1'b1);
    train(32'h3020, 32'h6660, 1'b1, BR_RET);
    expect_pred(32'h3020, 32'h1404, 1'b1, 1'b1);
    train(32'h3020, 32'h6660, 1'b1, BR_RET);
    expect_pred(32'h3020, 32'h1304, 1'b1, 1'b1);
    train(32'h3020, 32'h6660, 1'b1, BR_RET);
    expect_pred(32'h3020, 32'h1204, 1'b1, 1'b1);
    // Count saturated at 4, so four pops empty it
    train(32'h3020, 32'h6660, 1'b1, BR_RET);
    expect_pred(32'h3020, 32'h6660, 1'b1, 1'b1);

    // Random mix over 0x0..0x7C, two tags per index
    // About three quarters of the cycles carry a strobe
    for (int i = 0; i < RAND_N; i++) begin
      rnd   = $random(seed);
      rnd_f = $random(seed);
      drive(rnd[0] | rnd[9], XLEN'(rnd[8:4]) << 2, XLEN'({rnd[31:20], 2'b00}),
            rnd[1], br_kind_e'(rnd[3:2]), XLEN'(rnd_f[4:0]) << 2);
    end

    repeat (2) drive(1'b0, resolve_pc, resolve_tgt, resolve_taken, resolve_kind, fetch_pc);
    @(posedge clk);
    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== files.f ====
hw/bp_pkg.sv
hw/bp_ifs.sv
hw/bp_btb.sv
hw/bp_ras.sv
hw/bp_resolve.sv
hw/bp_next_pc.sv
hw/bp_top.sv
+incdir+verification
verification/bp_tb.sv
